// File: sources.f
+incdir+verification
verilog/robPkg.sv
verilog/cdbArbiter.sv
verilog/robOperandBuffer.sv
verilog/robCommitQueue.sv
verilog/robSubsystem.sv
verification/robTb.sv

// File: runSim.sh
#!/bin/sh
# Compile with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module robTb -o robSim > build.log 2>&1 \
  && ./obj_dir/robSim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// File: verification/robModel.svh
// Reference model of the reorder buffer, included inside the testbench module
// clearModel at reset, then each cycle predictCycle with the driven inputs and
// clockModel to apply the rising edge
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

logic [DATA_WIDTH-1:0]         mValue   [ROB_DEPTH]; // Broadcast results
logic [ROB_DEPTH-1:0]          mReady;
allocEntry                     mMeta    [ROB_DEPTH]; // Rename data per entry
logic [DATA_WIDTH-1:0]         mTarget  [ROB_DEPTH];
logic [CONTROL_FLOW_WIDTH-1:0] mControl [ROB_DEPTH]; // {isControl, pcControl}
logic [ROB_BITS-1:0]           mRead;
logic [ROB_BITS-1:0]           mWrite;
commitPacket                   mCommit;      // Expected registered commit bus
cdbPacket                      mCdb;         // Expected winner of this cycle
logic                          mStall;
logic                          mCommitNow;
logic                          mFlush;
logic                          mAlloc;
logic [DATA_WIDTH-1:0]         mHeadTarget;
logic [CONTROL_FLOW_WIDTH-1:0] mHeadControl;

function automatic logic onBus(input logic [ROB_BITS-1:0] tag);
  return mCdb.valid && (mCdb.robEntry == tag);
endfunction

function automatic logic entryReady(input logic [ROB_BITS-1:0] tag);
  return mReady[tag] || onBus(tag); // Same cycle broadcast counts
endfunction

function automatic logic [DATA_WIDTH-1:0] entryValue(input logic [ROB_BITS-1:0] tag);
  return onBus(tag) ? mCdb.result : mValue[tag];
endfunction

function automatic logic bufferFull();
  return (mWrite + 1'b1) == mRead; // Seven of eight occupied
endfunction

task automatic clearModel();
  mRead   = '0;
  mWrite  = '0;
  mReady  = '0;
  mCommit = '0; // Idle bus, kindAlu
  mCdb    = '0;
endtask

task automatic predictCycle(input logic write, input logic hold, input cdbPacket br,
                            input cdbPacket alu);
  mCdb   = br.valid ? br : alu; // Branch unit has priority
  mStall = br.valid && alu.valid;
  if (onBus(mRead)) begin
    mHeadTarget  = mCdb.isControl ? mCdb.targetAddress : '0;
    mHeadControl = mCdb.isControl ? {1'b1, mCdb.pcControl} : '0;
  end else begin
    mHeadTarget  = mTarget[mRead];
    mHeadControl = mControl[mRead];
  end
  mCommitNow = entryReady(mRead) && (mRead != mWrite);
  mFlush     = mCommitNow && mHeadControl[REDIRECT_BIT];
  mAlloc     = write && !hold && !bufferFull() && !mFlush; // Dropped on redirect
endtask

task automatic clockModel(input allocEntry entry);
  mCommit.validCommit = 1'b0; // Payload holds without a commit
  mCommit.kind        = kindAlu;
  mCommit.controlFlow = '0;
  if (mCommitNow) begin
    mCommit = '{validCommit: 1'b1, robEntry: mRead, result: entryValue(mRead),
                kind: mMeta[mRead].kind, destination: mMeta[mRead].destination,
                oldPC: mMeta[mRead].instrPC, statusSnap: mMeta[mRead].regStatus,
                previousIndex: mMeta[mRead].phtIndex, controlFlow: mHeadControl,
                targetAddress: mHeadTarget};
  end
  if (mCdb.valid) begin
    mValue[mCdb.robEntry] = mCdb.result;
    mReady[mCdb.robEntry] = 1'b1;
    if (mCdb.isControl) begin
      mTarget[mCdb.robEntry]  = mCdb.targetAddress;
      mControl[mCdb.robEntry] = {1'b1, mCdb.pcControl};
    end
  end
  if (mAlloc) begin
    mMeta[mWrite]    = entry;
    mReady[mWrite]   = 1'b0;
    mTarget[mWrite]  = '0;
    mControl[mWrite] = '0;
    mWrite           = mWrite + 1'b1;
  end
  if (mFlush) begin
    mReady = '0;
    mWrite = mRead + 1'b1; // Empty, restarting after the redirect
  end
  if (mCommitNow) mRead = mRead + 1'b1;
endtask

`endif

// File: verification/robTb.sv
// Self-checking testbench of the reorder buffer subsystem
// Random allocation, broadcast and operand traffic from a fixed seed, compared each
// cycle against the reference model; one line per test, then the totals
`timescale 1ns/1ps

module robTb import robPkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int TEST_CYCLES = 3 + 1 + 30 + 60 + 200 + 100 + 200; // Reset plus tests
  localparam int MARGIN      = 50;

  logic                  clk;
  logic                  reset;
  logic                  robWrite;
  logic                  freeze;
  allocEntry             inputEntry;
  cdbPacket              branchResult;
  cdbPacket              aluResult;
  logic [ROB_BITS-1:0]   rob1;
  logic [ROB_BITS-1:0]   rob2;
  logic [DATA_WIDTH-1:0] robValue1;
  logic [DATA_WIDTH-1:0] robValue2;
  logic                  valid1;
  logic                  valid2;
  logic                  full;
  logic [ROB_BITS-1:0]   robAllocation;
  logic                  aluStall;
  commitPacket           commitBus;

  int                   seed = 32'h1a77_f016;
  int                   checkCount;
  int                   errorCount;
  int                   markChecks;    // Totals when the current test started
  int                   markErrors;
  int                   writeRate;     // Out of 16
  int                   bcastRate;     // Out of 16, per unit
  logic                 redirectOn;
  logic [ROB_DEPTH-1:0] issued;        // Broadcast already driven for the entry
  cdbPacket             aluHeld;       // Stalled ALU packet, re-driven next cycle
  logic                 sawFull;
  logic                 sawStall;
  logic                 sawRedirect;

  `include "robModel.svh"

  robSubsystem UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("TB FAILED");
    $finish;
  end

  function automatic int randomBelow(input int range);
    return int'($unsigned($random(seed)) % range);
  endfunction

  task automatic checkValue(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] expected);
    checkCount++;
    assert (got === expected) else begin
      $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input logic seen, input string what);
    checkCount++;
    assert (seen) else begin
      $display("%s", what);
      errorCount++;
    end
  endtask

  // Random held entry whose broadcast is still outstanding
  task automatic pickEntry(output logic found, output logic [ROB_BITS-1:0] tag);
    logic [ROB_BITS-1:0] candidates [$];
    logic [ROB_BITS-1:0] t;
    t = mRead;
    while (t != mWrite) begin
      if (!issued[t]) candidates.push_back(t);
      t = t + 1'b1;
    end
    found = candidates.size() > 0;
    tag   = found ? candidates[randomBelow(candidates.size())] : '0;
  endtask

  task automatic makePacket(input logic [ROB_BITS-1:0] tag, input logic control,
                            output cdbPacket p);
    p.valid         = 1'b1;
    p.robEntry      = tag;
    p.result        = $random(seed);
    p.targetAddress = $random(seed);
    p.isControl     = control;
    p.pcControl     = {4'(randomBelow(16)), redirectOn && control && (randomBelow(8) == 0)};
    issued[tag]     = 1'b1;
  endtask

  task automatic driveInputs();
    logic                found;
    logic [ROB_BITS-1:0] tag;
    robWrite               = randomBelow(16) < writeRate;
    freeze                 = randomBelow(8) == 0;
    inputEntry.destination = $random(seed);
    inputEntry.kind        = commitKind'(2'(randomBelow(4)));
    inputEntry.instrPC     = $random(seed);
    inputEntry.phtIndex    = 8'(randomBelow(256));
    inputEntry.regStatus   = $random(seed);
    rob1                   = ROB_BITS'(randomBelow(ROB_DEPTH));
    rob2                   = ROB_BITS'(randomBelow(ROB_DEPTH));
    branchResult           = '0;
    aluResult              = aluHeld; // Idle unless a stalled packet waits
    if (randomBelow(16) < bcastRate) begin
      pickEntry(found, tag);
      if (found) makePacket(tag, randomBelow(4) != 0, branchResult); // Mostly control
    end
    if (!aluHeld.valid && randomBelow(16) < bcastRate) begin
      pickEntry(found, tag);
      if (found) makePacket(tag, 1'b0, aluResult);
    end
  endtask

  // Called 2 ns after a rising edge, returns 2 ns after the next one
  task automatic stepCycle();
    logic [ROB_BITS-1:0] afterTag;
    driveInputs();
    predictCycle(robWrite, freeze, branchResult, aluResult);
    if (mAlloc) issued[mWrite] = 1'b0; // Fresh entry, no broadcast yet
    #(CLK_PERIOD / 2 - 2);
    checkValue("aluStall", 32'(aluStall), 32'(mStall));
    checkValue("full", 32'(full), 32'(bufferFull()));
    checkValue("robAllocation", 32'(robAllocation), 32'(mWrite));
    checkValue("valid1", 32'(valid1), 32'(entryReady(rob1)));
    checkValue("valid2", 32'(valid2), 32'(entryReady(rob2)));
    if (entryReady(rob1)) checkValue("robValue1", robValue1, entryValue(rob1));
    if (entryReady(rob2)) checkValue("robValue2", robValue2, entryValue(rob2));
    checkValue("commitBus.validCommit", 32'(commitBus.validCommit), 32'(mCommit.validCommit));
    checkValue("commitBus.kind", 32'(commitBus.kind), 32'(mCommit.kind));
    checkValue("commitBus.controlFlow", 32'(commitBus.controlFlow), 32'(mCommit.controlFlow));
    if (mCommit.validCommit) begin
      checkValue("commitBus.robEntry", 32'(commitBus.robEntry), 32'(mCommit.robEntry));
      checkValue("commitBus.result", commitBus.result, mCommit.result);
      checkValue("commitBus.destination", commitBus.destination, mCommit.destination);
      checkValue("commitBus.oldPC", commitBus.oldPC, mCommit.oldPC);
      checkValue("commitBus.statusSnap", commitBus.statusSnap, mCommit.statusSnap);
      checkValue("commitBus.previousIndex", 32'(commitBus.previousIndex),
                 32'(mCommit.previousIndex));
      checkValue("commitBus.targetAddress", commitBus.targetAddress, mCommit.targetAddress);
    end
    if (mCommit.validCommit && mCommit.controlFlow[REDIRECT_BIT]) begin
      afterTag = mCommit.robEntry + 1'b1; // Buffer restarts past the redirect
      checkValue("robAllocation after redirect", 32'(robAllocation), 32'(afterTag));
    end
    sawFull     |= bufferFull();
    sawStall    |= mStall;
    sawRedirect |= mFlush;
    clockModel(inputEntry);
    aluHeld = '0;
    if (mStall && !mFlush) aluHeld = aluResult; // Loser holds its packet
    @(posedge clk);
    #2;
  endtask

  // needs is {full, stall, redirect}, each of which must occur during the test
  task automatic runTest(input int number, input string name, input int cycles,
                         input int writes, input int broadcasts, input logic redirects,
                         input logic [2:0] needs);
    writeRate   = writes;
    bcastRate   = broadcasts;
    redirectOn  = redirects;
    sawFull     = 1'b0;
    sawStall    = 1'b0;
    sawRedirect = 1'b0;
    repeat (cycles) stepCycle();
    if (needs[2]) checkFlag(sawFull, "Buffer never became full during the test");
    if (needs[1]) checkFlag(sawStall, "No CDB conflict occurred during the test");
    if (needs[0]) checkFlag(sawRedirect, "No redirect commit occurred during the test");
    $display("Test %0d %s finished: %0d checks, %0d errors", number, name,
             checkCount - markChecks, errorCount - markErrors);
    markChecks = checkCount;
    markErrors = errorCount;
  endtask

  initial begin
    reset        = 1'b0;
    robWrite     = 1'b0;
    freeze       = 1'b0;
    inputEntry   = '0;
    branchResult = '0;
    aluResult    = '0;
    rob1         = '0;
    rob2         = '0;
    checkCount   = 0;
    errorCount   = 0;
    markChecks   = 0;
    markErrors   = 0;
    issued       = '0;
    aluHeld      = '0;
    clearModel();
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b1;
    checkValue("commitBus.validCommit", 32'(commitBus.validCommit), 32'h0);
    checkValue("full", 32'(full), 32'h0);
    checkValue("robAllocation", 32'(robAllocation), 32'h0);
    runTest(1, "reset state", 1, 0, 0, 1'b0, 3'b000);
    runTest(2, "allocation and full", 30, 12, 0, 1'b0, 3'b100);
    runTest(3, "CDB conflict", 60, 8, 14, 1'b0, 3'b010);
    runTest(4, "in-order commit", 200, 10, 8, 1'b0, 3'b000);
    runTest(5, "operand reads", 100, 10, 12, 1'b0, 3'b000);
    runTest(6, "redirect flush", 200, 10, 10, 1'b1, 3'b001);
    $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/robSubsystem.sv
// Top level of the reorder buffer subsystem
// Arbitrates the branch and ALU results onto the CDB, tracks results and ready bits
// per entry and retires in order onto the registered commit bus
`timescale 1ns/1ps

module robSubsystem import robPkg::*; (
  input  logic                  clk,
  input  logic                  reset,         // Synchronous, active low
  input  logic                  robWrite,
  input  logic                  freeze,
  input  allocEntry             inputEntry,
  input  cdbPacket              branchResult,
  input  cdbPacket              aluResult,
  input  logic [ROB_BITS-1:0]   rob1,
  input  logic [ROB_BITS-1:0]   rob2,
  output logic [DATA_WIDTH-1:0] robValue1,
  output logic [DATA_WIDTH-1:0] robValue2,
  output logic                  valid1,
  output logic                  valid2,
  output logic                  full,
  output logic [ROB_BITS-1:0]   robAllocation,
  output logic                  aluStall,
  output commitPacket           commitBus
);

  cdbPacket              cdb;         // Winning broadcast
  logic                  headReady;
  logic [DATA_WIDTH-1:0] headValue;
  logic [ROB_BITS-1:0]   headPtr;
  logic                  allocStrobe;
  logic [ROB_BITS-1:0]   allocTag;
  logic                  flush;

  cdbArbiter arbiter (.branchResult(branchResult), .aluResult(aluResult), .cdb(cdb),
                      .aluStall(aluStall));

  robOperandBuffer operands (.clk(clk), .reset(reset), .cdb(cdb), .allocStrobe(allocStrobe),
                             .allocTag(allocTag), .flush(flush), .headPtr(headPtr),
                             .headReady(headReady), .headValue(headValue), .rob1(rob1),
                             .rob2(rob2), .robValue1(robValue1), .robValue2(robValue2),
                             .valid1(valid1), .valid2(valid2));

  robCommitQueue queue (.clk(clk), .reset(reset), .robWrite(robWrite), .freeze(freeze),
                        .inputEntry(inputEntry), .cdb(cdb), .headReady(headReady),
                        .headValue(headValue), .headPtr(headPtr), .allocStrobe(allocStrobe),
                        .allocTag(allocTag), .flush(flush), .full(full),
                        .robAllocation(robAllocation), .commitBus(commitBus));

endmodule

// File: verilog/robCommitQueue.sv
// Circular pointers and per-entry metadata of the reorder buffer
// Accepts allocations from rename, retires the head in order onto a registered
// commit bus and empties the buffer when a committing entry carries a redirect
// Head readiness and value come from the operand buffer, which owns the results
`timescale 1ns/1ps

module robCommitQueue import robPkg::*; (
  input  logic                  clk,
  input  logic                  reset,        // Synchronous, active low
  input  logic                  robWrite,     // Rename wants an entry
  input  logic                  freeze,       // Pipeline frozen, ignore robWrite
  input  allocEntry             inputEntry,
  input  cdbPacket              cdb,
  input  logic                  headReady,    // Includes same cycle bypass
  input  logic [DATA_WIDTH-1:0] headValue,
  output logic [ROB_BITS-1:0]   headPtr,
  output logic                  allocStrobe,
  output logic [ROB_BITS-1:0]   allocTag,
  output logic                  flush,
  output logic                  full,
  output logic [ROB_BITS-1:0]   robAllocation, // Tag of the next accepted write
  output commitPacket           commitBus
);

  logic [ROB_BITS-1:0] readPtr;  // Oldest entry
  logic [ROB_BITS-1:0] writePtr; // Next free entry

  // Metadata written at allocation
  logic [DATA_WIDTH-1:0]         destMem  [ROB_DEPTH];
  commitKind                     kindMem  [ROB_DEPTH];
  logic [DATA_WIDTH-1:0]         pcMem    [ROB_DEPTH];
  logic [INDEX_WIDTH-1:0]        indexMem [ROB_DEPTH];
  logic [DATA_WIDTH-1:0]         snapMem  [ROB_DEPTH];
  // Control flow info written by CDB control broadcasts
  logic [DATA_WIDTH-1:0]         targetMem  [ROB_DEPTH];
  logic [CONTROL_FLOW_WIDTH-1:0] controlMem [ROB_DEPTH];

  logic                          empty;
  logic                          headBypass; // Head result is on the CDB now
  logic                          commitNow;
  logic [ROB_BITS-1:0]           nextRead;
  logic [DATA_WIDTH-1:0]         headTarget;
  logic [CONTROL_FLOW_WIDTH-1:0] headControl;

  always_comb begin
    empty    = (readPtr == writePtr);
    full     = ((writePtr + 1'b1) == readPtr); // One slot kept free
    nextRead = readPtr + 1'b1;

    headBypass = cdb.valid && (cdb.robEntry == readPtr);
    commitNow  = headReady && !empty;

    // Bypassed head takes target and control from the bus, non-control reads zero
    if (headBypass) begin
      headTarget  = cdb.isControl ? cdb.targetAddress : '0;
      headControl = cdb.isControl ? {1'b1, cdb.pcControl} : '0;
    end else begin
      headTarget  = targetMem[readPtr];
      headControl = controlMem[readPtr];
    end

    flush = commitNow && headControl[REDIRECT_BIT]; // Mispredicted control commit

    // Write acceptance
    allocStrobe = robWrite && !freeze && !full && !flush && reset;
  end

  assign headPtr       = readPtr;
  assign allocTag      = writePtr;
  assign robAllocation = writePtr;

  // Metadata storage per entry
  always_ff @(posedge clk) begin
    if (allocStrobe) begin
      destMem[writePtr]    <= inputEntry.destination;
      kindMem[writePtr]    <= inputEntry.kind;
      pcMem[writePtr]      <= inputEntry.instrPC;
      indexMem[writePtr]   <= inputEntry.phtIndex;
      snapMem[writePtr]    <= inputEntry.regStatus;
      targetMem[writePtr]  <= '0; // Stays zero unless a control broadcast arrives
      controlMem[writePtr] <= '0;
    end
    if (cdb.valid && cdb.isControl) begin
      targetMem[cdb.robEntry]  <= cdb.targetAddress;
      controlMem[cdb.robEntry] <= {cdb.isControl, cdb.pcControl};
    end
  end

  // Pointers
  always_ff @(posedge clk) begin
    if (!reset) begin
      readPtr  <= '0;
      writePtr <= '0;
    end else begin
      if (commitNow) begin
        readPtr <= nextRead;
      end
      // Redirect restarts both pointers past the committing entry
      if (flush) begin
        writePtr <= nextRead;
      end else if (allocStrobe) begin
        writePtr <= writePtr + 1'b1;
      end
    end
  end

  // Registered commit bus
  always_ff @(posedge clk) begin
    if (!reset) begin
      commitBus.validCommit <= 1'b0;
      commitBus.kind        <= kindAlu;
      commitBus.controlFlow <= '0;
    end else if (commitNow) begin
      commitBus.validCommit   <= 1'b1;
      commitBus.robEntry      <= readPtr;
      commitBus.result        <= headValue; // Already bypassed by the operand buffer
      commitBus.kind          <= kindMem[readPtr];
      commitBus.destination   <= destMem[readPtr];
      commitBus.oldPC         <= pcMem[readPtr];
      commitBus.statusSnap    <= snapMem[readPtr];
      commitBus.previousIndex <= indexMem[readPtr];
      commitBus.controlFlow   <= headControl;
      commitBus.targetAddress <= headTarget;
    end else begin
      // State changing fields go inactive, payload holds
      commitBus.validCommit <= 1'b0;
      commitBus.kind        <= kindAlu;
      commitBus.controlFlow <= '0;
    end
  end

endmodule

// File: verilog/robOperandBuffer.sv
// Result values and ready bits of every reorder buffer entry
// Records CDB broadcasts and answers the two operand lookups of dispatch and the
// head query of the commit logic, all with bypass from the current broadcast
`timescale 1ns/1ps

module robOperandBuffer import robPkg::*; (
  input  logic                  clk,
  input  logic                  reset,       // Synchronous, active low
  input  cdbPacket              cdb,
  input  logic                  allocStrobe, // Accepted allocation this cycle
  input  logic [ROB_BITS-1:0]   allocTag,
  input  logic                  flush,       // Redirect commit empties the buffer
  input  logic [ROB_BITS-1:0]   headPtr,
  output logic                  headReady,
  output logic [DATA_WIDTH-1:0] headValue,
  input  logic [ROB_BITS-1:0]   rob1,
  input  logic [ROB_BITS-1:0]   rob2,
  output logic [DATA_WIDTH-1:0] robValue1,
  output logic [DATA_WIDTH-1:0] robValue2,
  output logic                  valid1,
  output logic                  valid2
);

  logic [DATA_WIDTH-1:0] valueMem [ROB_DEPTH]; // Result per entry
  logic [ROB_DEPTH-1:0]  readyBits;            // Result has been broadcast

  // Broadcast for this tag is on the bus right now
  function automatic logic cdbHit(input logic [ROB_BITS-1:0] tag);
    return cdb.valid && (cdb.robEntry == tag);
  endfunction

  function automatic logic lookupReady(input logic [ROB_BITS-1:0] tag);
    return readyBits[tag] | cdbHit(tag);
  endfunction

  // Bus value wins over storage since storage is written only at the edge
  function automatic logic [DATA_WIDTH-1:0] lookupValue(input logic [ROB_BITS-1:0] tag);
    logic [DATA_WIDTH-1:0] value;
    value = cdbHit(tag) ? cdb.result : valueMem[tag];
    return value;
  endfunction

  always_comb begin
    headReady = lookupReady(headPtr);
    headValue = lookupValue(headPtr);
    valid1    = lookupReady(rob1);    // Operand port 1
    robValue1 = lookupValue(rob1);
    valid2    = lookupReady(rob2);    // Operand port 2
    robValue2 = lookupValue(rob2);
  end

  // Ready tracking
  always_ff @(posedge clk) begin
    if (!reset || flush) begin
      readyBits <= '0; // Nothing in flight survives a redirect
    end else begin
      if (cdb.valid) begin
        readyBits[cdb.robEntry] <= 1'b1;
      end
      if (allocStrobe) begin
        readyBits[allocTag] <= 1'b0; // New owner of this slot waits for its result
      end
    end
  end

  // Value storage
  always_ff @(posedge clk) begin
    if (cdb.valid) begin
      valueMem[cdb.robEntry] <= cdb.result;
    end
  end

endmodule

// File: verilog/cdbArbiter.sv
// Fixed priority arbiter for the common data bus
// The branch unit always wins; the ALU is stalled and holds its packet when both
// units present a valid result in the same cycle
`timescale 1ns/1ps

module cdbArbiter import robPkg::*; (
  input  cdbPacket branchResult, // Branch unit result, high priority
  input  cdbPacket aluResult,    // ALU result, low priority
  output cdbPacket cdb,          // Single broadcaster of this cycle
  output logic     aluStall      // ALU lost and must re-drive
);

  logic branchWins;
  logic conflict;

  always_comb begin
    branchWins = branchResult.valid;
    conflict   = branchResult.valid & aluResult.valid; // Both want the bus

    // Branch first so misprediction recovery is never delayed
    if (branchWins) begin
      cdb = branchResult;
    end else begin
      cdb = aluResult; // Idle bus when the ALU is not valid either
    end

    aluStall = conflict;
  end

endmodule

// File: verilog/robPkg.sv
// Shared widths, the commit kind encoding and the bus structs of the reorder buffer
// Import with a wildcard in the module header of every block that needs them
package robPkg;

  localparam int DATA_WIDTH         = 32; // Values, addresses, PCs and snapshots
  localparam int ROB_DEPTH          = 8;
  localparam int ROB_BITS           = 3;  // Entry tag width
  localparam int INDEX_WIDTH        = 8;  // Gshare table index
  localparam int PC_CONTROL_WIDTH   = 5;  // {nextState, writeBTB, takenBranch, redirect}
  localparam int CONTROL_FLOW_WIDTH = PC_CONTROL_WIDTH + 1; // isControl on top
  localparam int REDIRECT_BIT       = 0;  // Misprediction redirect inside pcControl

  // What the committing instruction updates
  typedef enum logic [1:0] {
    kindAlu    = 2'd0, // Register write
    kindStore  = 2'd1, // Memory write
    kindBranch = 2'd2,
    kindJump   = 2'd3
  } commitKind;

  // Written by the rename stage at allocation
  typedef struct packed {
    logic [DATA_WIDTH-1:0]  destination;
    commitKind              kind;
    logic [DATA_WIDTH-1:0]  instrPC;
    logic [INDEX_WIDTH-1:0] phtIndex;
    logic [DATA_WIDTH-1:0]  regStatus; // Register status snapshot for recovery
  } allocEntry;

  // One broadcast on the common data bus
  typedef struct packed {
    logic                        valid;
    logic [ROB_BITS-1:0]         robEntry;
    logic [DATA_WIDTH-1:0]       result;
    logic [DATA_WIDTH-1:0]       targetAddress; // Resolved fetch address
    logic                        isControl;
    logic [PC_CONTROL_WIDTH-1:0] pcControl;
  } cdbPacket;

  // Registered retirement record
  typedef struct packed {
    logic                          validCommit;
    logic [ROB_BITS-1:0]           robEntry;
    logic [DATA_WIDTH-1:0]         result;
    commitKind                     kind;
    logic [DATA_WIDTH-1:0]         destination;
    logic [DATA_WIDTH-1:0]         oldPC;
    logic [DATA_WIDTH-1:0]         statusSnap;
    logic [INDEX_WIDTH-1:0]        previousIndex;
    logic [CONTROL_FLOW_WIDTH-1:0] controlFlow; // {isControl, pcControl}
    logic [DATA_WIDTH-1:0]         targetAddress;
  } commitPacket;

endpackage
